// File: design/rename_pkg.sv
package rename_pkg;

	// Physical tag width allows up to 64 physical registers
	localparam int PHYS_TAG_BITS = 6;
	localparam int ARCH_IDX_BITS = 5;

	typedef logic [PHYS_TAG_BITS-1:0] phys_tag_t;
	typedef logic [ARCH_IDX_BITS-1:0] arch_reg_t;

	// One map entry, the ready bit says the value is already on the CDB
	typedef struct packed {
		phys_tag_t phys_tag;
		logic      ready;
	} map_row_t;

	// Defaults for the top-level parameters
	localparam int DEFAULT_NUM_ARCH_REG   = 8;
	localparam int DEFAULT_NUM_PHYS_REG   = 16;
	localparam int DEFAULT_DISPATCH_WIDTH = 2;

endpackage

// File: design/cdb_pkg.sv
package cdb_pkg;

	import rename_pkg::*;

	// Execution units sharing the common data bus
	localparam int DEFAULT_NUM_UNITS = 3;

	// A broadcast carries the physical tag of the finished result
	typedef phys_tag_t cdb_tag_t;

endpackage

// File: design/tag_cam.sv
`timescale 1ns/1ps

module tag_cam #(
	parameter int NUM_ROWS = rename_pkg::DEFAULT_NUM_ARCH_REG,
	parameter int NUM_TAGS = 1
) (
	input  rename_pkg::phys_tag_t [NUM_ROWS-1:0] row_tags,
	input  cdb_pkg::cdb_tag_t     [NUM_TAGS-1:0] tags,
	input  logic                  [NUM_TAGS-1:0] tag_valid,
	output logic                  [NUM_ROWS-1:0] hits
);

	// Every row compares against every broadcast in parallel
	always_comb begin
		for (int r = 0; r < NUM_ROWS; r++) begin
			hits[r] = 1'b0;
			for (int t = 0; t < NUM_TAGS; t++) begin
				if (tag_valid[t] && (tags[t] == row_tags[r])) begin
					hits[r] = 1'b1;
				end
			end
		end
	end

endmodule

// File: design/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter #(
	parameter int NUM_UNITS = cdb_pkg::DEFAULT_NUM_UNITS
) (
	input  logic                              clock,
	input  logic                              reset,
	input  logic              [NUM_UNITS-1:0] complete_req,
	input  cdb_pkg::cdb_tag_t [NUM_UNITS-1:0] complete_tag,
	output logic              [NUM_UNITS-1:0] complete_grant,
	output logic                              cdb_valid,
	output cdb_pkg::cdb_tag_t                 cdb_tag
);

	localparam int PTR_BITS = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

	logic [PTR_BITS-1:0] prio_ptr; // First unit looked at this cycle
	logic [PTR_BITS-1:0] winner;
	logic                found;

	// Scan from the pointer around the ring, first requester wins
	always_comb begin : pick
		int idx;
		found  = 1'b0;
		winner = prio_ptr;
		for (int k = 0; k < NUM_UNITS; k++) begin
			idx = (int'(prio_ptr) + k) % NUM_UNITS;
			if (!found && complete_req[idx]) begin
				found  = 1'b1;
				winner = PTR_BITS'(idx);
			end
		end
	end

	always_comb begin
		complete_grant         = '0;
		complete_grant[winner] = found;
	end

	assign cdb_valid = found;
	assign cdb_tag   = complete_tag[winner]; // Only meaningful with cdb_valid

	// Winner drops to lowest priority for the next round
	always_ff @(posedge clock) begin
		if (reset) begin
			prio_ptr <= '0;
		end else if (found) begin
			prio_ptr <= (winner == PTR_BITS'(NUM_UNITS - 1)) ? '0 : winner + 1'b1;
		end
	end

	a_grant_legal: assert property (@(posedge clock) disable iff (reset)
		$onehot0(complete_grant) && ((complete_grant & ~complete_req) == '0))
		else $error("CDB grant %b does not fit requests %b", complete_grant, complete_req);

endmodule

// File: design/free_list.sv
`timescale 1ns/1ps

module free_list #(
	parameter int NUM_ARCH_REG   = rename_pkg::DEFAULT_NUM_ARCH_REG,
	parameter int NUM_PHYS_REG   = rename_pkg::DEFAULT_NUM_PHYS_REG,
	parameter int DISPATCH_WIDTH = rename_pkg::DEFAULT_DISPATCH_WIDTH
) (
	input  logic                                       clock,
	input  logic                                       reset,
	input  logic                  [DISPATCH_WIDTH-1:0] dispatch_valid,
	input  logic                  [DISPATCH_WIDTH-1:0] retire_valid,
	input  rename_pkg::phys_tag_t [DISPATCH_WIDTH-1:0] retire_tag,
	input  logic                                       branch_dispatch,
	input  logic                                       branch_mispredict,
	output logic                  [DISPATCH_WIDTH-1:0] alloc_ok,
	output rename_pkg::phys_tag_t [DISPATCH_WIDTH-1:0] free_tag
);

	import rename_pkg::*;

	localparam int DEPTH    = NUM_PHYS_REG - NUM_ARCH_REG;
	localparam int IDX_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	// Queue pointer is an index plus a lap bit that flips on every wrap
	typedef logic [IDX_BITS:0] ptr_t;

	phys_tag_t entries [DEPTH];

	ptr_t                head;
	ptr_t                tail;
	ptr_t                saved_head; // Head at the last branch
	ptr_t                head_next;
	ptr_t                tail_next;
	ptr_t                wr_slot [DISPATCH_WIDTH];
	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] count_next;
	logic [CNT_BITS-1:0] taken;
	logic [CNT_BITS-1:0] returned;

	function automatic ptr_t ptr_inc(input ptr_t p);
		if (p[IDX_BITS-1:0] == IDX_BITS'(DEPTH - 1)) begin
			return {~p[IDX_BITS], {IDX_BITS{1'b0}}};
		end
		return p + 1'b1;
	endfunction

	// Entries from one pointer up to another, the lap bits tell full from empty
	function automatic logic [CNT_BITS-1:0] ptr_dist(input ptr_t from, input ptr_t to);
		int span;
		span = int'(to[IDX_BITS-1:0]) - int'(from[IDX_BITS-1:0]);
		if (from[IDX_BITS] != to[IDX_BITS]) begin
			span += DEPTH;
		end
		return CNT_BITS'(span);
	endfunction

	// Lanes take entries in order, lane 0 first, until the queue runs dry
	always_comb begin : alloc
		ptr_t rd_ptr;
		rd_ptr = head;
		taken  = '0;
		for (int l = 0; l < DISPATCH_WIDTH; l++) begin
			free_tag[l] = entries[rd_ptr[IDX_BITS-1:0]];
			alloc_ok[l] = dispatch_valid[l] && !branch_mispredict && (taken < count);
			if (alloc_ok[l]) begin
				rd_ptr = ptr_inc(rd_ptr);
				taken  = taken + 1'b1;
			end
		end
		head_next = branch_mispredict ? saved_head : rd_ptr;
	end

	// Retired tags go to the tail, lane 0 first
	always_comb begin : give_back
		ptr_t wr_ptr;
		wr_ptr   = tail;
		returned = '0;
		for (int l = 0; l < DISPATCH_WIDTH; l++) begin
			wr_slot[l] = wr_ptr;
			if (retire_valid[l]) begin
				wr_ptr   = ptr_inc(wr_ptr);
				returned = returned + 1'b1;
			end
		end
		tail_next = wr_ptr;
	end

	// After recovery everything from the restored head to the tail is free
	assign count_next = branch_mispredict ? ptr_dist(head_next, tail_next)
		: count - taken + returned;

	always_ff @(posedge clock) begin
		if (reset) begin
			head       <= '0;
			tail       <= {1'b1, {IDX_BITS{1'b0}}}; // Full, same index on the next lap
			saved_head <= '0;
			count      <= CNT_BITS'(DEPTH);
			for (int i = 0; i < DEPTH; i++) begin
				entries[i] <= phys_tag_t'(NUM_ARCH_REG + i);
			end
		end else begin
			head  <= head_next;
			tail  <= tail_next;
			count <= count_next;
			if (branch_dispatch) begin
				saved_head <= head_next;
			end
			for (int l = 0; l < DISPATCH_WIDTH; l++) begin
				if (retire_valid[l]) begin
					entries[wr_slot[l][IDX_BITS-1:0]] <= retire_tag[l];
				end
			end
		end
	end

	// Overflow here means a tag was retired twice
	a_count_bound: assert property (@(posedge clock) disable iff (reset)
		count <= CNT_BITS'(DEPTH))
		else $error("Free list holds %0d tags, capacity %0d", count, DEPTH);

	// Pointers meeting on the same lap mean the queue is empty
	a_alloc_nonempty: assert property (@(posedge clock) disable iff (reset)
		(head == tail) |-> (alloc_ok == '0))
		else $error("Allocation granted from an empty free list");

endmodule

// File: design/map_table.sv
`timescale 1ns/1ps

module map_table #(
	parameter int NUM_ARCH_REG   = rename_pkg::DEFAULT_NUM_ARCH_REG,
	parameter int NUM_PHYS_REG   = rename_pkg::DEFAULT_NUM_PHYS_REG,
	parameter int DISPATCH_WIDTH = rename_pkg::DEFAULT_DISPATCH_WIDTH
) (
	input  logic                                       clock,
	input  logic                                       reset,
	input  logic                  [DISPATCH_WIDTH-1:0] rename_en,
	input  rename_pkg::arch_reg_t [DISPATCH_WIDTH-1:0] src_a,
	input  rename_pkg::arch_reg_t [DISPATCH_WIDTH-1:0] src_b,
	input  rename_pkg::arch_reg_t [DISPATCH_WIDTH-1:0] dest,
	input  rename_pkg::phys_tag_t [DISPATCH_WIDTH-1:0] new_tag,
	input  logic                                       cdb_valid,
	input  cdb_pkg::cdb_tag_t                          cdb_tag,
	input  logic                                       branch_dispatch,
	input  logic                                       branch_mispredict,
	output rename_pkg::map_row_t  [DISPATCH_WIDTH-1:0] tag_a,
	output rename_pkg::map_row_t  [DISPATCH_WIDTH-1:0] tag_b,
	output rename_pkg::phys_tag_t [DISPATCH_WIDTH-1:0] t_old
);

	import rename_pkg::*;

	localparam int ROW_BITS = (NUM_ARCH_REG > 1) ? $clog2(NUM_ARCH_REG) : 1;

	map_row_t  [NUM_ARCH_REG-1:0] map_q;
	map_row_t  [NUM_ARCH_REG-1:0] map_woken;  // Current map after this cycle's broadcast
	map_row_t  [NUM_ARCH_REG-1:0] map_next;
	map_row_t  [NUM_ARCH_REG-1:0] ckpt_q;
	map_row_t  [NUM_ARCH_REG-1:0] ckpt_woken;
	phys_tag_t [NUM_ARCH_REG-1:0] map_tags;
	phys_tag_t [NUM_ARCH_REG-1:0] ckpt_tags;
	logic      [NUM_ARCH_REG-1:0] map_hits;
	logic      [NUM_ARCH_REG-1:0] ckpt_hits;

	function automatic logic [ROW_BITS-1:0] row(input arch_reg_t r);
		return r[ROW_BITS-1:0];
	endfunction

	always_comb begin
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			map_tags[i]  = map_q[i].phys_tag;
			ckpt_tags[i] = ckpt_q[i].phys_tag;
		end
	end

	tag_cam #(
		.NUM_ROWS (NUM_ARCH_REG),
		.NUM_TAGS (1)
	) map_cam (
		.row_tags  (map_tags),
		.tags      (cdb_tag),
		.tag_valid (cdb_valid),
		.hits      (map_hits)
	);

	// The checkpoint copy listens to the same bus so recovery keeps ready bits
	tag_cam #(
		.NUM_ROWS (NUM_ARCH_REG),
		.NUM_TAGS (1)
	) checkpoint_cam (
		.row_tags  (ckpt_tags),
		.tags      (cdb_tag),
		.tag_valid (cdb_valid),
		.hits      (ckpt_hits)
	);

	always_comb begin : wakeup
		map_woken  = map_q;
		ckpt_woken = ckpt_q;
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			map_woken[i].ready  = map_q[i].ready | map_hits[i];
			ckpt_woken[i].ready = ckpt_q[i].ready | ckpt_hits[i];
		end
	end

	// Lanes in program order, so lane 1 sees lane 0's new mapping
	always_comb begin : lanes
		map_next = map_woken;
		for (int l = 0; l < DISPATCH_WIDTH; l++) begin
			tag_a[l] = map_next[row(src_a[l])];
			tag_b[l] = map_next[row(src_b[l])];
			t_old[l] = map_next[row(dest[l])].phys_tag;
			if (rename_en[l] && !branch_mispredict) begin
				map_next[row(dest[l])].phys_tag = new_tag[l];
				map_next[row(dest[l])].ready    = 1'b0; // Producer not done yet
			end
		end
		if (branch_mispredict) begin
			map_next = ckpt_woken;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ARCH_REG; i++) begin
				map_q[i]  <= '{phys_tag: phys_tag_t'(i), ready: 1'b1};
				ckpt_q[i] <= '{phys_tag: phys_tag_t'(i), ready: 1'b1};
			end
		end else begin
			map_q  <= map_next;
			ckpt_q <= branch_dispatch ? map_next : ckpt_woken;
		end
	end

	// Tags handed out by the free list must name a real physical register
	for (genvar l = 0; l < DISPATCH_WIDTH; l++) begin : g_lane_chk
		a_tag_range: assert property (@(posedge clock) disable iff (reset)
			rename_en[l] |-> (int'(new_tag[l]) < NUM_PHYS_REG))
			else $error("Lane %0d renamed to tag %0d outside the register file", l, new_tag[l]);
	end

endmodule

// File: design/rename_unit.sv
`timescale 1ns/1ps

module rename_unit #(
	parameter int NUM_ARCH_REG   = rename_pkg::DEFAULT_NUM_ARCH_REG,
	parameter int NUM_PHYS_REG   = rename_pkg::DEFAULT_NUM_PHYS_REG,
	parameter int DISPATCH_WIDTH = rename_pkg::DEFAULT_DISPATCH_WIDTH,
	parameter int NUM_UNITS      = cdb_pkg::DEFAULT_NUM_UNITS
) (
	input  logic                                       clock,
	input  logic                                       reset,
	// Dispatch, lane 0 is the older instruction
	input  logic                  [DISPATCH_WIDTH-1:0] dispatch_valid,
	input  rename_pkg::arch_reg_t [DISPATCH_WIDTH-1:0] src_a,
	input  rename_pkg::arch_reg_t [DISPATCH_WIDTH-1:0] src_b,
	input  rename_pkg::arch_reg_t [DISPATCH_WIDTH-1:0] dest,
	output logic                  [DISPATCH_WIDTH-1:0] renamed,
	output rename_pkg::map_row_t  [DISPATCH_WIDTH-1:0] tag_a,
	output rename_pkg::map_row_t  [DISPATCH_WIDTH-1:0] tag_b,
	output rename_pkg::phys_tag_t [DISPATCH_WIDTH-1:0] t_new,
	output rename_pkg::phys_tag_t [DISPATCH_WIDTH-1:0] t_old,
	// Completion requests stay up until granted
	input  logic                  [NUM_UNITS-1:0]      complete_req,
	input  cdb_pkg::cdb_tag_t     [NUM_UNITS-1:0]      complete_tag,
	output logic                  [NUM_UNITS-1:0]      complete_grant,
	// Retire
	input  logic                  [DISPATCH_WIDTH-1:0] retire_valid,
	input  rename_pkg::phys_tag_t [DISPATCH_WIDTH-1:0] retire_tag,
	// Single branch checkpoint
	input  logic                                       branch_dispatch,
	input  logic                                       branch_mispredict
);

	import rename_pkg::*;
	import cdb_pkg::*;

	logic     cdb_valid;
	cdb_tag_t cdb_tag;

	if (NUM_PHYS_REG > (1 << PHYS_TAG_BITS) ||
		NUM_PHYS_REG < NUM_ARCH_REG + DISPATCH_WIDTH) begin : g_bad_size
		$error("NUM_PHYS_REG %0d does not fit the map or the tag width", NUM_PHYS_REG);
	end

	cdb_arbiter #(
		.NUM_UNITS (NUM_UNITS)
	) u_cdb_arbiter (
		.clock          (clock),
		.reset          (reset),
		.complete_req   (complete_req),
		.complete_tag   (complete_tag),
		.complete_grant (complete_grant),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag)
	);

	// Accepted lanes and their new tags feed the map and leave as renamed and t_new
	free_list #(
		.NUM_ARCH_REG   (NUM_ARCH_REG),
		.NUM_PHYS_REG   (NUM_PHYS_REG),
		.DISPATCH_WIDTH (DISPATCH_WIDTH)
	) u_free_list (
		.clock             (clock),
		.reset             (reset),
		.dispatch_valid    (dispatch_valid),
		.retire_valid      (retire_valid),
		.retire_tag        (retire_tag),
		.branch_dispatch   (branch_dispatch),
		.branch_mispredict (branch_mispredict),
		.alloc_ok          (renamed),
		.free_tag          (t_new)
	);

	map_table #(
		.NUM_ARCH_REG   (NUM_ARCH_REG),
		.NUM_PHYS_REG   (NUM_PHYS_REG),
		.DISPATCH_WIDTH (DISPATCH_WIDTH)
	) u_map_table (
		.clock             (clock),
		.reset             (reset),
		.rename_en         (renamed),
		.src_a             (src_a),
		.src_b             (src_b),
		.dest              (dest),
		.new_tag           (t_new),
		.cdb_valid         (cdb_valid),
		.cdb_tag           (cdb_tag),
		.branch_dispatch   (branch_dispatch),
		.branch_mispredict (branch_mispredict),
		.tag_a             (tag_a),
		.tag_b             (tag_b),
		.t_old             (t_old)
	);

endmodule

// File: verification/rename_tests.svh
`ifndef RENAME_TESTS_SVH
`define RENAME_TESTS_SVH

task automatic retire_all();
	while (old_tags.size() > 0) begin
		retire_valid  = 2'b01;
		retire_tag[0] = phys_tag_t'(old_tags.pop_front());
		if (old_tags.size() > 0) begin
			retire_valid[1] = 1'b1;
			retire_tag[1]   = phys_tag_t'(old_tags.pop_front());
		end
		run_cycle();
	end
	retire_valid = '0;
endtask

task automatic reset_mapping_test();
	for (int i = 0; i < 8; i++) begin
		src_a[0] = arch_reg_t'(i);
		#10;
		check_value(tag_a[0], (i << 1) | 1, "mapping after reset");
		run_cycle();
	end
endtask

task automatic dependent_pair_test();
	dispatch_valid = 2'b11;
	dest[0]        = 5'd1;
	src_a[1]       = 5'd1; // Reads lane 0's destination
	dest[1]        = 5'd2;
	#10;
	check_value(t_new[0], 8, "lane 0 t_new");
	check_value(t_new[1], 9, "lane 1 t_new");
	check_value(tag_a[1], 8 << 1, "lane 1 source forwarded from lane 0");
	run_cycle();
	clear_inputs();
endtask

task automatic cdb_rotation_test();
	int         regs[3] = '{1, 2, 5};
	logic [2:0] pending;
	int         served;
	dispatch_valid = 2'b01;
	dest[0]        = 5'd5;
	run_cycle();
	clear_inputs();
	for (int u = 0; u < 3; u++) begin
		complete_tag[u] = cdb_tag_t'(m_tag[regs[u]]);
	end
	pending = 3'b111;
	served  = 0;
	while (pending != 3'b000) begin
		if (served == 6) begin
			report_timeout("CDB grants");
		end
		complete_req = 3'b111; // Served units ask again, only rotation reaches the rest
		run_cycle();
		check_value(last_grant, 3'b001 << served, "CDB grant order");
		pending = pending & ~last_grant;
		served++;
	end
	complete_req = '0;
	for (int u = 0; u < 3; u++) begin
		src_a[0] = arch_reg_t'(regs[u]);
		#10;
		check_value(tag_a[0].ready, 1'b1, "ready after broadcast");
		run_cycle();
	end
endtask

task automatic exhaustion_test();
	int returned[$];
	int tries;
	tries = 0;
	while (free_q.size() > 0) begin
		if (tries == 10) begin
			report_timeout("the free list to run empty");
		end
		dispatch_valid = 2'b11;
		dest[0]        = arch_reg_t'(random_below(8));
		dest[1]        = arch_reg_t'(random_below(8));
		run_cycle();
		tries++;
	end
	#10;
	check_value(renamed, 0, "renamed with an empty free list");
	run_cycle();
	clear_inputs();
	returned = old_tags;
	retire_all();
	for (int n = 0; n < 4; n++) begin
		dispatch_valid = 2'b11;
		dest[0]        = arch_reg_t'(random_below(8));
		dest[1]        = arch_reg_t'(random_below(8));
		#10;
		check_value(renamed, 2'b11, "renamed after retire");
		check_value(t_new[0], returned[2 * n], "lane 0 reuse order");
		check_value(t_new[1], returned[2 * n + 1], "lane 1 reuse order");
		run_cycle();
	end
	clear_inputs();
	retire_all();
endtask

task automatic mispredict_test();
	int saved_tag[8];
	bit saved_rdy[8];
	int saved_head;
	int bcast;
	int kept;
	int tries;
	dispatch_valid = 2'b11;
	dest[0]        = 5'd3;
	dest[1]        = 5'd4;
	run_cycle();
	clear_inputs();
	bcast           = m_tag[3];
	branch_dispatch = 1'b1;
	run_cycle();
	branch_dispatch = 1'b0;
	saved_tag  = m_tag;
	saved_rdy  = m_rdy;
	saved_head = free_q[0];
	kept       = old_tags.size();
	for (int n = 0; n < 2; n++) begin
		dispatch_valid = 2'b11;
		dest[0]        = 5'd3; // Overwrites the mapping of bcast
		dest[1]        = arch_reg_t'(6 + n);
		run_cycle();
	end
	clear_inputs();
	complete_req[0] = 1'b1;
	complete_tag[0] = cdb_tag_t'(bcast);
	tries           = 0;
	do begin
		if (tries == 4) begin
			report_timeout("the broadcast grant");
		end
		run_cycle();
		tries++;
	end while (!last_grant[0]);
	complete_req      = '0;
	branch_mispredict = 1'b1;
	dispatch_valid    = 2'b11;
	#10;
	check_value(renamed, 0, "renamed during mispredict");
	run_cycle();
	clear_inputs();
	while (old_tags.size() > kept) begin
		void'(old_tags.pop_back()); // Squashed renames never retire
	end
	for (int i = 0; i < 8; i++) begin
		src_a[0] = arch_reg_t'(i);
		#10;
		check_value(tag_a[0], (saved_tag[i] << 1) | ((i == 3) ? 1 : int'(saved_rdy[i])),
			"map after recovery");
		run_cycle();
	end
	dispatch_valid = 2'b01;
	dest[0]        = 5'd2;
	#10;
	check_value(t_new[0], saved_head, "allocation after recovery");
	run_cycle();
	clear_inputs();
endtask

task automatic random_stream_test();
	logic [2:0] waiting;
	waiting = '0;
	for (int c = 0; c < 40; c++) begin
		dispatch_valid = 2'(random_below(4));
		for (int l = 0; l < 2; l++) begin
			src_a[l]        = arch_reg_t'(random_below(8));
			src_b[l]        = arch_reg_t'(random_below(8));
			dest[l]         = arch_reg_t'(random_below(8));
			retire_valid[l] = 1'b0;
			if (old_tags.size() > 0 && random_below(2) == 1) begin
				retire_valid[l] = 1'b1;
				retire_tag[l]   = phys_tag_t'(old_tags.pop_front());
			end
		end
		waiting = waiting & ~last_grant;
		for (int u = 0; u < 3; u++) begin
			if (!waiting[u] && random_below(3) == 0) begin
				waiting[u]      = 1'b1;
				complete_tag[u] = cdb_tag_t'(random_below(16));
			end
		end
		complete_req = waiting;
		run_cycle();
	end
	clear_inputs();
endtask

`endif

// File: verification/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

	import rename_pkg::*;
	import cdb_pkg::*;

	logic            clock;
	logic            reset;
	logic      [1:0] dispatch_valid;
	arch_reg_t [1:0] src_a;
	arch_reg_t [1:0] src_b;
	arch_reg_t [1:0] dest;
	logic      [1:0] renamed;
	map_row_t  [1:0] tag_a;
	map_row_t  [1:0] tag_b;
	phys_tag_t [1:0] t_new;
	phys_tag_t [1:0] t_old;
	logic      [2:0] complete_req;
	cdb_tag_t  [2:0] complete_tag;
	logic      [2:0] complete_grant;
	logic      [1:0] retire_valid;
	phys_tag_t [1:0] retire_tag;
	logic            branch_dispatch;
	logic            branch_mispredict;

	// Reference model of map, ready bits, free queue and arbiter pointer
	int         m_tag [8];
	bit         m_rdy [8];
	int         c_tag [8]; // Checkpoint copy
	bit         c_rdy [8];
	int         free_q [$];
	int         ckpt_free [$]; // Free queue as seen from the checkpointed head
	int         old_tags [$];  // Replaced tags the ROB would retire later
	int         arb_ptr;
	logic [2:0] last_grant;
	int         seed = 32'h6c90;

	rename_unit u_rename_unit (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("Testbench failed");
			$fatal(1, "Value mismatch on %s", what);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Testbench failed");
		$fatal(1, "Wait limit reached");
	endtask

	function automatic int random_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic int row_value(input arch_reg_t r);
		return (m_tag[r] << 1) | int'(m_rdy[r]); // Same packing as map_row_t
	endfunction

	task automatic clear_inputs();
		dispatch_valid    = '0;
		src_a             = '0;
		src_b             = '0;
		dest              = '0;
		retire_valid      = '0;
		retire_tag        = '0;
		complete_req      = '0;
		complete_tag      = '0;
		branch_dispatch   = 1'b0;
		branch_mispredict = 1'b0;
	endtask

	task automatic reset_model();
		for (int i = 0; i < 8; i++) begin
			m_tag[i] = i;
			m_rdy[i] = 1'b1;
		end
		c_tag = m_tag;
		c_rdy = m_rdy;
		free_q.delete();
		for (int i = 8; i < 16; i++) begin
			free_q.push_back(i);
		end
		ckpt_free = free_q;
		old_tags.delete();
		arb_ptr    = 0;
		last_grant = '0;
	endtask

	// Checks one cycle against the model and steps both to the next falling edge
	task automatic run_cycle();
		int unit;
		int win;
		int cdb_t;
		int nt;
		bit cdb_v;
		bit ok;
		#20;
		cdb_v = 1'b0;
		win   = 0;
		cdb_t = 0;
		for (int k = 0; k < 3; k++) begin
			unit = (arb_ptr + k) % 3;
			if (!cdb_v && complete_req[unit]) begin
				cdb_v = 1'b1;
				win   = unit;
			end
		end
		last_grant = complete_grant;
		check_value(complete_grant, cdb_v ? (32'd1 << win) : 32'd0, "complete_grant");
		if (cdb_v) begin
			cdb_t   = complete_tag[win];
			arb_ptr = (win + 1) % 3;
		end
		for (int i = 0; i < 8; i++) begin
			if (cdb_v && m_tag[i] == cdb_t) begin
				m_rdy[i] = 1'b1;
			end
			if (cdb_v && c_tag[i] == cdb_t) begin
				c_rdy[i] = 1'b1;
			end
		end
		for (int l = 0; l < 2; l++) begin
			ok = dispatch_valid[l] && !branch_mispredict && free_q.size() > 0;
			check_value(renamed[l], ok, "renamed");
			check_value(tag_a[l], row_value(src_a[l]), "tag_a");
			check_value(tag_b[l], row_value(src_b[l]), "tag_b");
			check_value(t_old[l], m_tag[dest[l]], "t_old");
			if (ok) begin
				nt = free_q.pop_front();
				check_value(t_new[l], nt, "t_new");
				old_tags.push_back(m_tag[dest[l]]);
				m_tag[dest[l]] = nt;
				m_rdy[dest[l]] = 1'b0; // Lane 1 sees this write
			end
		end
		for (int l = 0; l < 2; l++) begin
			if (retire_valid[l]) begin
				free_q.push_back(retire_tag[l]);
				ckpt_free.push_back(retire_tag[l]);
			end
		end
		if (branch_mispredict) begin
			m_tag  = c_tag;
			m_rdy  = c_rdy;
			free_q = ckpt_free;
		end
		if (branch_dispatch) begin
			c_tag     = m_tag;
			c_rdy     = m_rdy;
			ckpt_free = free_q;
		end
		@(posedge clock);
		@(negedge clock);
	endtask

	`include "rename_tests.svh"

	initial begin
		clear_inputs();
		reset_model();
		reset = 1'b1;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		reset_mapping_test();
		dependent_pair_test();
		cdb_rotation_test();
		exhaustion_test();
		mispredict_test();
		random_stream_test();
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: project.f
+incdir+verification
design/rename_pkg.sv
design/cdb_pkg.sv
design/tag_cam.sv
design/cdb_arbiter.sv
design/free_list.sv
design/map_table.sv
design/rename_unit.sv
verification/rename_tb.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module rename_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module rename_tb \
		-Mdir $(OBJ_DIR) -o rename_sim
	./$(OBJ_DIR)/rename_sim

clean:
	rm -rf $(OBJ_DIR)
